/* build.f */
logic/ps2_timing_pkg.sv
logic/ps2_frame_pkg.sv
logic/ps2_bus_sync.sv
logic/ps2_rx.sv
logic/ps2_tx.sv
logic/ps2_host.sv
verification/ps2_host_tb.sv

/* logic/ps2_bus_sync.sv */
`timescale 1ns/1ps

module ps2_bus_sync (
  input  logic PS2_clk,
  input  logic reset,
  input  logic bus_clk,
  input  logic bus_data,
  output logic clk_level,
  output logic data_level,
  output logic clk_fall,
  output logic clk_rise
);

  // two stages per line, [1] is the safe one
  logic [1:0] clk_sync;
  logic [1:0] data_sync;

  // last synchronized clock level, for edges
  logic clk_prev;

  // an idle bus is high on both lines, so reset there
  always_ff @(posedge PS2_clk or posedge reset) begin
    if (reset) begin
      clk_sync  <= 2'b11;
      data_sync <= 2'b11;
      clk_prev  <= 1'b1;
    end else begin
      clk_sync  <= {clk_sync[0], bus_clk};
      data_sync <= {data_sync[0], bus_data};
      clk_prev  <= clk_sync[1];
    end
  end

  assign clk_level  = clk_sync[1];
  assign data_level = data_sync[1];

  // single cycle pulses, two cycles behind the pin
  assign clk_fall = clk_prev & ~clk_sync[1];
  assign clk_rise = ~clk_prev & clk_sync[1];

endmodule

/* logic/ps2_frame_pkg.sv */
package ps2_frame_pkg;

  ////////////////////////////////////////////////////////////////////
  // frame layout
  ////////////////////////////////////////////////////////////////////

  // start, eight data bits lsb first, parity, stop
  localparam int unsigned frame_bits = 11;

  // bit positions once a whole frame has been shifted in
  localparam int unsigned start_pos  = 0;
  localparam int unsigned data_lsb   = 1;
  localparam int unsigned data_msb   = 8;
  localparam int unsigned parity_pos = 9;
  localparam int unsigned stop_pos   = 10;

  // one data byte
  typedef logic [7:0] ps2_byte_t;

  // counts frame bits, up to frame_bits
  typedef logic [3:0] bit_count_t;

  ////////////////////////////////////////////////////////////////////
  // parity
  ////////////////////////////////////////////////////////////////////

  // parity bit that leaves data plus parity with an odd number of ones
  function automatic logic odd_parity(ps2_byte_t data);
    return ~(^data);
  endfunction

endpackage

/* logic/ps2_host.sv */
`timescale 1ns/1ps

module ps2_host
  import ps2_frame_pkg::*;
(
  input  logic      PS2_clk,
  input  logic      reset,
  input  logic      bus_clk,
  input  logic      bus_data,
  output logic      bus_clk_pull,
  output logic      bus_data_pull,
  input  ps2_byte_t tx_byte,
  input  logic      wr_en,
  output ps2_byte_t rx_byte,
  output logic      data_available,
  output logic      busy,
  output logic      err
);

  logic clk_level;
  logic data_level;
  logic clk_fall;
  logic clk_rise;
  logic tx_active;
  logic tx_err;
  logic rx_active;
  logic rx_err;

  ps2_bus_sync u_sync (
    .PS2_clk    (PS2_clk),
    .reset      (reset),
    .bus_clk    (bus_clk),
    .bus_data   (bus_data),
    .clk_level  (clk_level),
    .data_level (data_level),
    .clk_fall   (clk_fall),
    .clk_rise   (clk_rise)
  );

  ps2_rx u_rx (
    .PS2_clk        (PS2_clk),
    .reset          (reset),
    .clk_fall       (clk_fall),
    .data_level     (data_level),
    .tx_active      (tx_active),
    .rx_byte        (rx_byte),
    .data_available (data_available),
    .rx_err         (rx_err),
    .rx_active      (rx_active)
  );

  ps2_tx u_tx (
    .PS2_clk       (PS2_clk),
    .reset         (reset),
    .clk_fall      (clk_fall),
    .clk_rise      (clk_rise),
    .data_level    (data_level),
    .tx_byte       (tx_byte),
    .wr_en         (wr_en),
    .rx_active     (rx_active),
    .bus_clk_pull  (bus_clk_pull),
    .bus_data_pull (bus_data_pull),
    .tx_active     (tx_active),
    .tx_err        (tx_err)
  );

  assign busy = tx_active | rx_active;
  assign err  = rx_err | tx_err;

  // a held clock pull must show up as a low line past the synchronizer
  a_clk_pull_seen: assert property (@(posedge PS2_clk) disable iff (reset)
    bus_clk_pull [*3] |-> !clk_level);

endmodule

/* logic/ps2_rx.sv */
`timescale 1ns/1ps

module ps2_rx
  import ps2_frame_pkg::*;
(
  input  logic      PS2_clk,
  input  logic      reset,
  input  logic      clk_fall,
  input  logic      data_level,
  input  logic      tx_active,
  output ps2_byte_t rx_byte,
  output logic      data_available,
  output logic      rx_err,
  output logic      rx_active
);

  // frame enters from the left, start bit ends up in bit 0
  logic [frame_bits-1:0] rx_shift;
  bit_count_t            bit_cnt;

  logic frame_done;
  logic parity_ok;

  assign frame_done = rx_active && (bit_cnt == bit_count_t'(frame_bits));
  assign parity_ok  = rx_shift[parity_pos] == odd_parity(rx_shift[data_msb:data_lsb]);

  ////////////////////////////////////////////////////////////////////
  // shift in
  ////////////////////////////////////////////////////////////////////

  // device changes data while the clock is high, so sample on the fall
  always_ff @(posedge PS2_clk) begin
    if (clk_fall && !tx_active) begin
      rx_shift <= {data_level, rx_shift[frame_bits-1:1]};
    end
  end

  ////////////////////////////////////////////////////////////////////
  // frame control
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge PS2_clk or posedge reset) begin
    if (reset) begin
      rx_active      <= 1'b0;
      bit_cnt        <= '0;
      data_available <= 1'b0;
      rx_err         <= 1'b0;
    end else begin
      data_available <= 1'b0;
      rx_err         <= 1'b0;
      if (tx_active) begin
        // host owns the bus, drop any partial frame
        rx_active <= 1'b0;
        bit_cnt   <= '0;
      end else if (frame_done) begin
        rx_active <= 1'b0;
        bit_cnt   <= '0;
        if (parity_ok) begin
          data_available <= 1'b1;
        end else begin
          rx_err <= 1'b1;
        end
      end else if (clk_fall) begin
        // first fall of an idle bus opens a frame
        rx_active <= 1'b1;
        bit_cnt   <= bit_cnt + 1'b1;
      end
    end
  end

  // byte held until a later good frame replaces it
  always_ff @(posedge PS2_clk) begin
    if (frame_done && parity_ok && !tx_active) begin
      rx_byte <= rx_shift[data_msb:data_lsb];
    end
  end

  // a whole frame opens with a low start bit and closes with a high stop bit
  a_frame_bounds: assert property (@(posedge PS2_clk) disable iff (reset)
    frame_done |-> (!rx_shift[start_pos] && rx_shift[stop_pos]));

endmodule

/* logic/ps2_timing_pkg.sv */
package ps2_timing_pkg;

  ////////////////////////////////////////////////////////////////////
  // bus timing in system clock cycles, 25 MHz
  ////////////////////////////////////////////////////////////////////

  // clock held low before a request, 100 us
  localparam int unsigned inhibit_cycles = 2500;

  // data low with clock still low, 20 us
  localparam int unsigned rts_cycles = 500;

  // settle time after the clock is released
  localparam int unsigned first_clk_cycles = 300;

  // longest wait for the device acknowledge
  localparam int unsigned ack_timeout_cycles = 4095;

  // transmit delay counter, wide enough for every value above
  localparam int unsigned delay_width = 12;

endpackage

/* logic/ps2_tx.sv */
`timescale 1ns/1ps

module ps2_tx
  import ps2_timing_pkg::*;
  import ps2_frame_pkg::*;
(
  input  logic      PS2_clk,
  input  logic      reset,
  input  logic      clk_fall,
  input  logic      clk_rise,
  input  logic      data_level,
  input  ps2_byte_t tx_byte,
  input  logic      wr_en,
  input  logic      rx_active,
  output logic      bus_clk_pull,
  output logic      bus_data_pull,
  output logic      tx_active,
  output logic      tx_err
);

  typedef enum logic [2:0] {
    st_idle,
    st_inhibit,
    st_request,
    st_first_wait,
    st_shift,
    st_wait_release,
    st_ack
  } tx_state_t;

  tx_state_t state;
  tx_state_t state_next;

  // one counter for every timed phase
  logic [delay_width-1:0] delay_cnt;

  // data bits, parity, stop; bit 0 goes out next
  logic [frame_bits-2:0] tx_shift;

  // device clock falls seen in the shift phase
  bit_count_t tx_bits;

  logic clk_pull_q;
  logic data_pull_q;
  logic bit_step;
  logic last_fall;
  logic ack_timeout;

  // first fall leaves the start bit for the device to sample
  assign bit_step  = (state == st_shift) && clk_fall && (tx_bits != '0);
  assign last_fall = (state == st_shift) && clk_fall &&
                     (tx_bits == bit_count_t'(frame_bits - 1));
  assign ack_timeout = delay_cnt == delay_width'(ack_timeout_cycles - 1);

  ////////////////////////////////////////////////////////////////////
  // phase sequencing
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (wr_en && !rx_active) begin
          state_next = st_inhibit;
        end
      end
      st_inhibit: begin
        if (delay_cnt == delay_width'(inhibit_cycles - 1)) begin
          state_next = st_request;
        end
      end
      st_request: begin
        if (delay_cnt == delay_width'(rts_cycles - 1)) begin
          state_next = st_first_wait;
        end
      end
      st_first_wait: begin
        if (delay_cnt == delay_width'(first_clk_cycles - 1)) begin
          state_next = st_shift;
        end
      end
      st_shift: begin
        if (last_fall) begin
          state_next = st_wait_release;
        end
      end
      // device samples the stop bit on this rise
      st_wait_release: begin
        if (clk_rise) begin
          state_next = st_ack;
        end
      end
      st_ack: begin
        if (!data_level || ack_timeout) begin
          state_next = st_idle;
        end
      end
      default: state_next = st_idle;
    endcase
  end

  always_ff @(posedge PS2_clk or posedge reset) begin
    if (reset) begin
      state       <= st_idle;
      delay_cnt   <= '0;
      tx_bits     <= '0;
      clk_pull_q  <= 1'b0;
      data_pull_q <= 1'b0;
      tx_err      <= 1'b0;
    end else begin
      state <= state_next;

      // restart the count on every phase change
      if (state_next != state || state == st_idle) begin
        delay_cnt <= '0;
      end else begin
        delay_cnt <= delay_cnt + 1'b1;
      end

      if (state == st_idle) begin
        tx_bits <= '0;
      end else if (state == st_shift && clk_fall) begin
        tx_bits <= tx_bits + 1'b1;
      end

      clk_pull_q <= (state_next == st_inhibit) || (state_next == st_request);

      // start bit goes out with the request, then each bit inverted
      if (state_next == st_idle) begin
        data_pull_q <= 1'b0;
      end else if (state == st_inhibit && state_next == st_request) begin
        data_pull_q <= 1'b1;
      end else if (bit_step) begin
        data_pull_q <= ~tx_shift[0];
      end

      // acknowledge wins over a timeout in the same cycle
      tx_err <= (state == st_ack) && data_level && ack_timeout;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // frame payload
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge PS2_clk) begin
    if (state == st_idle && state_next == st_inhibit) begin
      tx_shift <= {1'b1, odd_parity(tx_byte), tx_byte};
    end else if (bit_step) begin
      tx_shift <= {1'b1, tx_shift[frame_bits-2:1]};
    end
  end

  assign bus_clk_pull  = clk_pull_q;
  assign bus_data_pull = data_pull_q;
  assign tx_active     = (state != st_idle);

  // a held data pull must read back as a low line past the synchronizer
  a_data_pull_seen: assert property (@(posedge PS2_clk) disable iff (reset)
    bus_data_pull [*3] |-> !data_level);

  // the bus is fully released whenever the transmitter is idle
  a_pull_when_active: assert property (@(posedge PS2_clk) disable iff (reset)
    (bus_clk_pull || bus_data_pull) |-> tx_active);

endmodule

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -f build.f --top-module ps2_host_tb \
  -o ps2_host_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/ps2_host_sim > sim.log 2>&1
cat sim.log
grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0

/* verification/ps2_host_tb.sv */
`timescale 1ns/1ps

module ps2_host_tb
  import ps2_timing_pkg::*;
  import ps2_frame_pkg::*;
();

  // device bus half period in system clocks
  localparam int bus_half = 40;

  logic      PS2_clk;
  logic      reset;
  logic      bus_clk;
  logic      bus_data;
  logic      bus_clk_pull;
  logic      bus_data_pull;
  ps2_byte_t tx_byte;
  logic      wr_en;
  ps2_byte_t rx_byte;
  logic      data_available;
  logic      busy;
  logic      err;

  // device side of the open-drain lines, 1 means released
  logic dev_clk_rel;
  logic dev_data_rel;

  int        dav_count;
  int        err_count;
  int        test_num;
  int        pass_count;
  int        fail_count;
  bit        test_ok;
  bit        aborted;
  ps2_byte_t last_good;
  logic [31:0] rng;

  ps2_host dut (
    .PS2_clk        (PS2_clk),
    .reset          (reset),
    .bus_clk        (bus_clk),
    .bus_data       (bus_data),
    .bus_clk_pull   (bus_clk_pull),
    .bus_data_pull  (bus_data_pull),
    .tx_byte        (tx_byte),
    .wr_en          (wr_en),
    .rx_byte        (rx_byte),
    .data_available (data_available),
    .busy           (busy),
    .err            (err)
  );

  always #4 PS2_clk = ~PS2_clk;

  // wired AND of both drivers
  assign bus_clk  = dev_clk_rel & ~bus_clk_pull;
  assign bus_data = dev_data_rel & ~bus_data_pull;

  // pulse counters, nonblocking so readers on the same edge see the old value
  always @(negedge PS2_clk) begin
    if (reset) begin
      dav_count <= 0;
      err_count <= 0;
    end else begin
      if (data_available) dav_count <= dav_count + 1;
      if (err) err_count <= err_count + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // bit that makes data plus parity hold an odd number of ones
  function automatic logic parity_for(input ps2_byte_t value);
    int ones;
    ones = 0;
    for (int k = 0; k < 8; k++) ones += value[k];
    return (ones % 2 == 0) ? 1'b1 : 1'b0;
  endfunction

  task automatic check_byte(input ps2_byte_t got, input ps2_byte_t exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
      test_ok = 0;
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
      test_ok = 0;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      test_ok = 0;
    end
  endtask

  task automatic report_abort(input string msg);
    $display("run stopped at %0t ns because %s", $time, msg);
    aborted = 1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // device model
  //////////////////////////////////////////////////////////////////////

  task automatic run_rx(input ps2_byte_t value, input bit bad_parity);
    logic [frame_bits-1:0] frame;
    int dav_base;
    int err_base;
    int n;
    int i;
    dav_base = dav_count;
    err_base = err_count;
    frame = {1'b1, parity_for(value) ^ bad_parity, value, 1'b0};
    // data set while the clock is high, host samples on the fall
    for (i = 0; i < frame_bits; i++) begin
      dev_data_rel = frame[i];
      repeat (bus_half) @(negedge PS2_clk);
      dev_clk_rel = 1'b0;
      repeat (bus_half) @(negedge PS2_clk);
      dev_clk_rel = 1'b1;
    end
    dev_data_rel = 1'b1;
    n = 0;
    while (dav_count == dav_base && err_count == err_base && n < 200) begin
      @(negedge PS2_clk);
      n++;
    end
    if (dav_count == dav_base && err_count == err_base) begin
      report_abort("neither data_available nor err came after a receive frame");
      return;
    end
    // room for a stray second pulse
    repeat (20) @(negedge PS2_clk);
    if (bad_parity) begin
      check_count(dav_count - dav_base, 0, "data_available pulses");
      check_count(err_count - err_base, 1, "err pulses");
      check_byte(rx_byte, last_good, "held rx_byte");
    end else begin
      check_count(dav_count - dav_base, 1, "data_available pulses");
      check_count(err_count - err_base, 0, "err pulses");
      check_byte(rx_byte, value, "rx_byte");
      last_good = value;
    end
  endtask

  task automatic run_tx(input ps2_byte_t value, input bit no_ack);
    logic [frame_bits-1:0] seen;
    int err_base;
    int n;
    int i;
    int pulls;
    err_base = err_count;
    tx_byte = value;
    wr_en = 1'b1;
    @(negedge PS2_clk);
    wr_en = 1'b0;
    check_flag(busy, 1'b1, "busy after wr_en");
    n = 0;
    while (!bus_clk_pull && n < 10) begin
      @(negedge PS2_clk);
      n++;
    end
    if (!bus_clk_pull) begin
      report_abort("the host never pulled the clock low after wr_en");
      return;
    end
    // inhibit phase, then request phase
    n = 0;
    while (bus_clk_pull && !bus_data_pull && n < inhibit_cycles + 100) begin
      n++;
      @(negedge PS2_clk);
    end
    check_count(n, inhibit_cycles, "clock only pull cycles");
    n = 0;
    while (bus_clk_pull && bus_data_pull && n < rts_cycles + 100) begin
      n++;
      @(negedge PS2_clk);
    end
    check_count(n, rts_cycles, "clock and data pull cycles");
    repeat (first_clk_cycles + 100) @(negedge PS2_clk);
    for (i = 0; i < frame_bits; i++) begin
      dev_clk_rel = 1'b0;
      repeat (bus_half) @(negedge PS2_clk);
      seen[i] = bus_data;
      dev_clk_rel = 1'b1;
      repeat (bus_half) @(negedge PS2_clk);
    end
    check_flag(seen[0], 1'b0, "start bit");
    check_byte(seen[8:1], value, "sent data bits");
    check_flag(seen[9], parity_for(value), "parity bit");
    check_flag(seen[10], 1'b1, "stop bit");
    if (!no_ack) dev_data_rel = 1'b0;
    n = 0;
    while (busy && n < ack_timeout_cycles + 200) begin
      @(negedge PS2_clk);
      n++;
    end
    dev_data_rel = 1'b1;
    if (busy) begin
      report_abort("busy never fell after the transmit");
      return;
    end
    repeat (5) @(negedge PS2_clk);
    check_count(err_count - err_base, no_ack ? 1 : 0, "err pulses");
    if (no_ack) begin
      // a retransmit would pull the clock again
      pulls = 0;
      repeat (3000) begin
        @(negedge PS2_clk);
        if (bus_clk_pull) pulls++;
      end
      check_count(pulls, 0, "clock pull cycles after timeout");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int code;
    int fault;
    int gap;
    logic [15:0] op;
    ps2_byte_t value;
    string line;
    PS2_clk = 1'b0;
    reset = 1'b1;
    tx_byte = '0;
    wr_en = 1'b0;
    dev_clk_rel = 1'b1;
    dev_data_rel = 1'b1;
    test_num = 0;
    pass_count = 0;
    fail_count = 0;
    aborted = 0;
    last_good = '0;
    rng = 32'hecf7_a23c;
    repeat (10) @(negedge PS2_clk);
    reset = 1'b0;
    fd = $fopen("verification/ps2_input.txt", "r");
    if (fd == 0) report_abort("the file verification/ps2_input.txt could not be opened");
    while (!aborted && $fgets(line, fd) > 0) begin
      if (line.len() < 4 || line.getc(0) == "#") continue;
      code = $sscanf(line, "%s %h %d", op, value, fault);
      if (code != 3) continue;
      rng = lcg_next(rng);
      gap = 1 + int'((rng >> 16) % 50);
      repeat (gap) @(negedge PS2_clk);
      test_num++;
      test_ok = 1;
      if (op == "rx") run_rx(value, fault != 0);
      else run_tx(value, fault != 0);
      if (test_ok && !aborted) pass_count++;
      else fail_count++;
      $display("test %0d %s %02h fault %0d: %s", test_num, op, value, fault,
               aborted ? "aborted" : (test_ok ? "ok" : "mismatch"));
    end
    if (fd != 0) $fclose(fd);
    $display("tests %0d, passed %0d, failed %0d", test_num, pass_count, fail_count);
    if (fail_count == 0 && !aborted && test_num > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* verification/ps2_input.txt */
# columns: operation (rx or tx), data byte in hex, fault flag
# fault 1 means bad parity on rx and a missing acknowledge on tx
rx 3c 0
rx a5 0
rx 00 1
rx ff 0
tx ed 0
rx 5a 0
rx 81 1
tx f4 0
tx 00 1
rx 12 0
rx 7e 0
tx ff 0
rx e0 1
rx f0 0
tx 55 1
rx 29 0
tx aa 0
tx 01 0
rx 80 0
rx c3 1
rx 6b 0
tx 3c 0
rx 99 0
rx 00 0
